/* build.f */
source/cpu_pkg.sv
source/cpu_sequencer.sv
source/program_counter.sv
source/register_file.sv
source/cpu_alu.sv
source/mem_access.sv
source/cpu_core.sv
verif/data_mem_model.sv
verif/cpu_core_tb.sv

/* source/cpu_alu.sv */
// ALU of the core; latches the source operand and combines it with the current register read
`timescale 1ns/1ps
`default_nettype none

module cpu_alu import cpu_pkg::*; #(
	parameter int word_w = 16
) (
	input  logic              clk,
	input  logic              mem_read_ready_stor_reset,
	input  logic              latch,
	input  opcode_e           op,
	input  logic [word_w-1:0] operand,
	output logic [word_w-1:0] result
);

	logic [word_w-1:0] operand_a;
	logic [7:0]        shamt;

	assign shamt = operand[7:0];

	always_ff @(posedge clk) begin
		if (mem_read_ready_stor_reset)
			operand_a <= '0;
		else if (latch)
			operand_a <= operand;
	end

	always_comb begin
		case (op)
			op_and: result = operand_a & operand;
			op_or:  result = operand_a | operand;
			op_xor: result = operand_a ^ operand;
			op_add: result = operand_a + operand;
			op_mul: result = operand_a * operand; // Low word only
			op_gt:  result = (operand_a > operand) ? '1 : '0;
			op_eq:  result = (operand_a == operand) ? '1 : '0;
			op_shift: begin
				if (shamt >= word_w)
					result = '0;
				else if (|operand[word_w-1:8])
					result = operand_a << shamt; // Upper byte set means left
				else
					result = operand_a >> shamt;
			end
			default: result = operand_a; // Memory address for MEMR / MEMW
		endcase
	end

endmodule

`default_nettype wire

/* source/cpu_core.sv */
// Top level of the 16-bit core; connects sequencer, PC, registers, ALU and the memory port
`timescale 1ns/1ps
`default_nettype none

module cpu_core import cpu_pkg::*; #(
	parameter int word_w = 16
) (
	input  logic              clk,
	input  logic              mem_read_ready_stor_reset,
	output logic [word_w-1:0] imem_addr,
	input  instr_t            imem_data,
	output mem_req_t          mem_req,
	input  mem_rsp_t          mem_rsp,
	output logic              halted
);

	logic [reg_addr_w-1:0] rd_addr;
	logic [reg_addr_w-1:0] wr_addr;
	logic                  wr_en;
	wr_src_e               wr_src;
	logic [word_w-1:0]     literal;
	logic                  alu_latch;
	opcode_e               alu_op;
	pc_step_e              pc_step;
	logic                  fetch_next;
	logic                  mem_start_read;
	logic                  mem_start_write;
	logic                  mem_done;
	logic [word_w-1:0]     rd_data;
	logic [word_w-1:0]     wr_data;
	logic [word_w-1:0]     alu_result;
	logic [word_w-1:0]     mem_rdata;
	logic [word_w-1:0]     pc;

	// SET literal sits right after the instruction
	assign imem_addr = fetch_next ? pc + word_w'(1) : pc;

	cpu_sequencer u_cpu_sequencer (
		.clk                       (clk),
		.mem_read_ready_stor_reset (mem_read_ready_stor_reset),
		.imem_data                 (imem_data),
		.rd_data                   (rd_data),
		.mem_done                  (mem_done),
		.rd_addr                   (rd_addr),
		.wr_addr                   (wr_addr),
		.wr_en                     (wr_en),
		.wr_src                    (wr_src),
		.literal                   (literal),
		.alu_latch                 (alu_latch),
		.alu_op                    (alu_op),
		.pc_step                   (pc_step),
		.fetch_next                (fetch_next),
		.mem_start_read            (mem_start_read),
		.mem_start_write           (mem_start_write),
		.halted                    (halted)
	);

	program_counter u_program_counter (
		.clk                       (clk),
		.mem_read_ready_stor_reset (mem_read_ready_stor_reset),
		.step                      (pc_step),
		.target                    (wr_data),
		.pc                        (pc)
	);

	register_file #(.word_w(word_w)) u_register_file (
		.clk                       (clk),
		.mem_read_ready_stor_reset (mem_read_ready_stor_reset),
		.rd_addr                   (rd_addr),
		.rd_data                   (rd_data),
		.wr_addr                   (wr_addr),
		.wr_en                     (wr_en),
		.wr_src                    (wr_src),
		.literal                   (literal),
		.alu_result                (alu_result),
		.mem_rdata                 (mem_rdata),
		.pc                        (pc),
		.wr_data                   (wr_data)
	);

	cpu_alu #(.word_w(word_w)) u_cpu_alu (
		.clk                       (clk),
		.mem_read_ready_stor_reset (mem_read_ready_stor_reset),
		.latch                     (alu_latch),
		.op                        (alu_op),
		.operand                   (rd_data),
		.result                    (alu_result)
	);

	// Address from the latched source register, data from the current read
	mem_access u_mem_access (
		.clk                       (clk),
		.mem_read_ready_stor_reset (mem_read_ready_stor_reset),
		.start_read                (mem_start_read),
		.start_write               (mem_start_write),
		.addr                      (alu_result),
		.wdata                     (rd_data),
		.mem_req                   (mem_req),
		.mem_rsp                   (mem_rsp),
		.done                      (mem_done),
		.rdata                     (mem_rdata)
	);

endmodule

`default_nettype wire

/* source/cpu_pkg.sv */
// Shared widths, opcodes, state codes and port structs; imported by every core block
`default_nettype none

package cpu_pkg;

	localparam int word_w     = 16;
	localparam int reg_addr_w = 4;
	localparam int pc_reg     = 15; // Register 15 reads and writes the PC
	localparam int mem_addr_w = 15;

	typedef enum logic [3:0] {
		op_halt  = 4'h0,
		op_mov   = 4'h1,
		op_movnz = 4'h2,
		op_movez = 4'h3,
		op_bus   = 4'h4, // Executes as a halt
		op_memr  = 4'h5,
		op_set   = 4'h6,
		op_memw  = 4'h7,
		op_and   = 4'h8,
		op_or    = 4'h9,
		op_xor   = 4'ha,
		op_add   = 4'hb,
		op_shift = 4'hc,
		op_mul   = 4'hd,
		op_gt    = 4'he,
		op_eq    = 4'hf
	} opcode_e;

	// Nibble order matches the instruction word, high to low
	typedef struct packed {
		logic [reg_addr_w-1:0] cond_reg;
		logic [reg_addr_w-1:0] dst_reg;
		logic [reg_addr_w-1:0] src_reg;
		opcode_e               opcode;
	} instr_t;

	typedef enum logic [1:0] {
		st_ins_load = 2'd0,
		st_execute  = 2'd1,
		st_commit   = 2'd2,
		st_advance  = 2'd3
	} seq_state_e;

	typedef enum logic [1:0] {
		wr_move    = 2'd0, // Register read data
		wr_literal = 2'd1,
		wr_alu     = 2'd2,
		wr_memory  = 2'd3
	} wr_src_e;

	typedef enum logic [1:0] {
		pc_hold     = 2'd0,
		pc_step_one = 2'd1,
		pc_step_two = 2'd2,
		pc_load     = 2'd3
	} pc_step_e;

	typedef struct packed {
		logic                  read;  // Level, held until ready
		logic                  write; // Single-cycle pulse
		logic [mem_addr_w-1:0] addr;
		logic [word_w-1:0]     wdata;
	} mem_req_t;

	typedef struct packed {
		logic              ready; // Single-cycle pulse
		logic [word_w-1:0] rdata;
	} mem_rsp_t;

endpackage

`default_nettype wire

/* source/cpu_sequencer.sv */
// Instruction FSM of the core; loads, executes, commits and advances each instruction
`timescale 1ns/1ps
`default_nettype none

module cpu_sequencer import cpu_pkg::*; (
	input  logic                  clk,
	input  logic                  mem_read_ready_stor_reset,
	input  instr_t                imem_data,
	input  logic [word_w-1:0]     rd_data,
	input  logic                  mem_done,
	output logic [reg_addr_w-1:0] rd_addr,
	output logic [reg_addr_w-1:0] wr_addr,
	output logic                  wr_en,
	output wr_src_e               wr_src,
	output logic [word_w-1:0]     literal,
	output logic                  alu_latch,
	output opcode_e               alu_op,
	output pc_step_e              pc_step,
	output logic                  fetch_next,
	output logic                  mem_start_read,
	output logic                  mem_start_write,
	output logic                  halted
);

	seq_state_e state;
	instr_t     ir;
	logic       exec_phase; // Set after the first execute cycle
	logic       cond_ok;    // Result of the MOVNZ / MOVEZ test
	logic       is_alu;
	logic       writes_reg;
	logic       cond_test;
	logic       exec_done;
	logic       to_pc;

	assign is_alu     = (ir.opcode >= op_and);
	assign writes_reg = !(ir.opcode inside {op_halt, op_bus, op_memw});
	assign to_pc      = writes_reg && cond_ok && (ir.dst_reg == reg_addr_w'(pc_reg));

	always_comb begin
		case (ir.opcode)
			op_movnz: cond_test = |rd_data;
			op_movez: cond_test = ~|rd_data;
			default:  cond_test = 1'b1;
		endcase
	end

	// Last execute cycle of the current instruction
	always_comb begin
		case (ir.opcode)
			op_mov, op_memw: exec_done = 1'b1;
			op_memr:         exec_done = mem_done;
			op_halt, op_bus: exec_done = 1'b0; // Stuck until reset
			default:         exec_done = exec_phase;
		endcase
	end

	always_ff @(posedge clk) begin
		if (mem_read_ready_stor_reset) begin
			state      <= st_ins_load;
			ir         <= '0;
			exec_phase <= 1'b0;
			cond_ok    <= 1'b0;
		end else begin
			case (state)
				st_ins_load: begin
					ir         <= imem_data;
					cond_ok    <= 1'b1;
					exec_phase <= 1'b0;
					state      <= st_execute;
				end
				st_execute: begin
					if (exec_phase)
						cond_ok <= cond_test; // Condition register is on the read port now
					if (exec_done)
						state <= st_commit;
					exec_phase <= 1'b1;
				end
				st_commit: state <= st_advance;
				default:   state <= st_ins_load;
			endcase
		end
	end

	// Word after SET, read through the PC plus one
	always_ff @(posedge clk) begin
		if (fetch_next)
			literal <= imem_data;
	end

	// Source first, then the condition register
	always_comb begin
		rd_addr = ir.src_reg;
		case (state)
			st_ins_load: rd_addr = imem_data.src_reg; // Feeds the ALU operand latch
			st_execute: begin
				if (ir.opcode == op_memw)
					rd_addr = ir.cond_reg; // Store data
				else if (exec_phase && (is_alu || ir.opcode inside {op_movnz, op_movez}))
					rd_addr = ir.cond_reg;
			end
			default: begin
				if (is_alu)
					rd_addr = ir.cond_reg; // Keeps the ALU result stable
			end
		endcase
	end

	always_comb begin
		case (ir.opcode)
			op_set:  wr_src = wr_literal;
			op_memr: wr_src = wr_memory;
			default: wr_src = is_alu ? wr_alu : wr_move;
		endcase
	end

	always_comb begin
		pc_step = pc_hold;
		if (state == st_advance) begin
			if (to_pc)
				pc_step = pc_load; // Branch
			else if (ir.opcode == op_set)
				pc_step = pc_step_two; // Skip the literal
			else
				pc_step = pc_step_one;
		end
	end

	assign wr_addr         = ir.dst_reg;
	assign wr_en           = (state == st_commit) && writes_reg && cond_ok && !to_pc;
	assign alu_latch       = (state == st_ins_load);
	assign alu_op          = ir.opcode;
	assign fetch_next      = (state == st_execute) && (ir.opcode == op_set) && exec_phase;
	assign mem_start_read  = (state == st_execute) && (ir.opcode == op_memr) && !exec_phase;
	assign mem_start_write = (state == st_execute) && (ir.opcode == op_memw);
	assign halted          = (state == st_execute) && (ir.opcode inside {op_halt, op_bus});

endmodule

`default_nettype wire

/* source/mem_access.sv */
// Data memory port; drives read and write strobes and captures the read ready pulse
`timescale 1ns/1ps
`default_nettype none

module mem_access import cpu_pkg::*; (
	input  logic              clk,
	input  logic              mem_read_ready_stor_reset,
	input  logic              start_read,
	input  logic              start_write,
	input  logic [word_w-1:0] addr,
	input  logic [word_w-1:0] wdata,
	output mem_req_t          mem_req,
	input  mem_rsp_t          mem_rsp,
	output logic              done,
	output logic [word_w-1:0] rdata
);

	logic read_busy;   // Read held after its first cycle
	logic ready_stor;  // Latched ready, high one cycle
	logic read_active;

	assign read_active = start_read | read_busy;

	always_ff @(posedge clk) begin
		if (mem_read_ready_stor_reset) begin
			read_busy  <= 1'b0;
			ready_stor <= 1'b0;
		end else begin
			read_busy  <= read_active & ~mem_rsp.ready;
			ready_stor <= read_active & mem_rsp.ready;
		end
	end

	// Holds the loaded word until the register commit
	always_ff @(posedge clk) begin
		if (read_active && mem_rsp.ready)
			rdata <= mem_rsp.rdata;
	end

	assign done = ready_stor;

	always_comb begin
		mem_req.read  = read_active;
		mem_req.write = start_write;
		mem_req.addr  = addr[mem_addr_w-1:0]; // Bit 15 ignored
		mem_req.wdata = wdata;
	end

endmodule

`default_nettype wire

/* source/program_counter.sv */
// Program address counter; steps by one or two per instruction or loads a branch target
`timescale 1ns/1ps
`default_nettype none

module program_counter import cpu_pkg::*; (
	input  logic              clk,
	input  logic              mem_read_ready_stor_reset,
	input  pc_step_e          step,
	input  logic [word_w-1:0] target,
	output logic [word_w-1:0] pc
);

	always_ff @(posedge clk) begin
		if (mem_read_ready_stor_reset) begin
			pc <= '0;
		end else begin
			case (step)
				pc_step_one: pc <= pc + word_w'(1);
				pc_step_two: pc <= pc + word_w'(2); // SET and its literal
				pc_load:     pc <= target;          // Committed write to register 15
				default:     pc <= pc;
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/register_file.sv */
// General register file with one read port; register 15 maps onto the program counter
`timescale 1ns/1ps
`default_nettype none

module register_file import cpu_pkg::*; #(
	parameter int word_w = 16
) (
	input  logic                  clk,
	input  logic                  mem_read_ready_stor_reset,
	input  logic [reg_addr_w-1:0] rd_addr,
	output logic [word_w-1:0]     rd_data,
	input  logic [reg_addr_w-1:0] wr_addr,
	input  logic                  wr_en,
	input  wr_src_e               wr_src,
	input  logic [word_w-1:0]     literal,
	input  logic [word_w-1:0]     alu_result,
	input  logic [word_w-1:0]     mem_rdata,
	input  logic [word_w-1:0]     pc,
	output logic [word_w-1:0]     wr_data
);

	logic [word_w-1:0] regs [pc_reg]; // r0 to r14

	assign rd_data = (rd_addr == reg_addr_w'(pc_reg)) ? pc : regs[rd_addr];

	// Also the branch target for the PC
	always_comb begin
		case (wr_src)
			wr_literal: wr_data = literal;
			wr_alu:     wr_data = alu_result;
			wr_memory:  wr_data = mem_rdata;
			default:    wr_data = rd_data;
		endcase
	end

	always_ff @(posedge clk) begin
		if (mem_read_ready_stor_reset) begin
			for (int i = 0; i < pc_reg; i++)
				regs[i] <= '0;
		end else if (wr_en && (wr_addr != reg_addr_w'(pc_reg))) begin
			regs[wr_addr] <= wr_data;
		end
	end

endmodule

`default_nettype wire

/* verif/cpu_core_tb.sv */
// Testbench for the core; runs one program through ALU, moves, memory access, a loop and HALT
`timescale 1ns/1ps
`default_nettype none

module cpu_core_tb import cpu_pkg::*; ();

	localparam int reset_cycles   = 8;
	localparam int max_read_delay = 6;
	localparam int num_programs   = 1;

	logic                  clk;
	logic                  mem_read_ready_stor_reset;
	logic [word_w-1:0]     imem_addr;
	instr_t                imem_data;
	mem_req_t              mem_req;
	mem_rsp_t              mem_rsp;
	logic                  halted;
	logic [word_w-1:0]     prog [256];
	int unsigned           prog_len;
	logic [mem_addr_w-1:0] exp_addr [$];
	logic [word_w-1:0]     exp_data [$];
	int unsigned           checks;
	int unsigned           errors;
	int unsigned           timeout_cycles;

	initial clk = 1'b0;
	always #4 clk = ~clk;

	assign imem_data = prog[imem_addr[7:0]]; // Combinational instruction port

	cpu_core #(.word_w(word_w)) u_cpu_core (
		.clk                       (clk),
		.mem_read_ready_stor_reset (mem_read_ready_stor_reset),
		.imem_addr                 (imem_addr),
		.imem_data                 (imem_data),
		.mem_req                   (mem_req),
		.mem_rsp                   (mem_rsp),
		.halted                    (halted)
	);

	data_mem_model #(.max_delay(max_read_delay)) u_data_mem_model (
		.clk                       (clk),
		.mem_read_ready_stor_reset (mem_read_ready_stor_reset),
		.mem_req                   (mem_req),
		.mem_rsp                   (mem_rsp)
	);

	task automatic report_error(string msg);
		errors++;
		$display("error %0t: %s", $time, msg);
	endtask

	task automatic check_value(string what, logic [word_w-1:0] got, logic [word_w-1:0] exp);
		checks++;
		assert (got === exp)
			else report_error($sformatf("%s is %h, expected %h", what, got, exp));
	endtask

	task automatic check_idle(string when);
		checks++;
		assert (!mem_req.read && !mem_req.write && !halted && imem_addr == '0)
			else report_error($sformatf("core not idle %s", when));
	endtask

	// Cond, dst, src and opcode from the high nibble down
	function automatic logic [word_w-1:0] encode(opcode_e op, int src, int dst, int cond);
		return {4'(cond), 4'(dst), 4'(src), op};
	endfunction

	function automatic logic [word_w-1:0] alu_expect(opcode_e op, logic [word_w-1:0] a,
			logic [word_w-1:0] b);
		logic [2*word_w-1:0] product;
		product = a * b;
		case (op)
			op_and: return a & b;
			op_or:  return a | b;
			op_xor: return a ^ b;
			op_add: return a + b;
			op_mul: return product[word_w-1:0];
			op_gt:  return (a > b) ? '1 : '0;
			op_eq:  return (a == b) ? '1 : '0;
			op_shift: begin
				if (b[7:0] >= word_w)
					return '0;
				else if (b[word_w-1:8] != '0)
					return a << b[7:0]; // Upper byte set shifts left
				return a >> b[7:0];
			end
			default: return 'x;
		endcase
	endfunction

	task automatic put_word(logic [word_w-1:0] w);
		prog[prog_len] = w;
		prog_len++;
	endtask

	task automatic put_set(int dst, logic [word_w-1:0] value);
		put_word(encode(op_set, 0, dst, 0));
		put_word(value);
	endtask

	task automatic put_store(int addr_reg, int data_reg, logic [mem_addr_w-1:0] addr,
			logic [word_w-1:0] data);
		put_word(encode(op_memw, addr_reg, 0, data_reg));
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	assert property (@(posedge clk) disable iff (mem_read_ready_stor_reset)
		mem_req.read && !mem_rsp.ready |=> mem_req.read)
		else report_error("read dropped before ready");
	assert property (@(posedge clk) disable iff (mem_read_ready_stor_reset)
		mem_rsp.ready |=> !mem_req.read)
		else report_error("read still high after ready");
	assert property (@(posedge clk) disable iff (mem_read_ready_stor_reset)
		mem_req.write |=> !mem_req.write)
		else report_error("write pulse longer than one cycle");
	assert property (@(posedge clk) disable iff (mem_read_ready_stor_reset)
		halted |=> halted)
		else report_error("halted dropped before reset");
	assert property (@(posedge clk) disable iff (mem_read_ready_stor_reset)
		halted |-> !mem_req.read && !mem_req.write)
		else report_error("memory access while halted");

	initial begin
		logic [word_w-1:0] a;
		logic [word_w-1:0] b;
		logic [word_w-1:0] c;
		logic [word_w-1:0] d;
		logic [word_w-1:0] e;
		int unsigned       count;
		int unsigned       loop_top;
		void'($urandom(32'h11b3_ce8c));
		mem_read_ready_stor_reset = 1'b1;
		prog_len = 0;
		for (int i = 0; i < 256; i++)
			prog[i] = '0; // Unused words halt

		a = 16'($urandom) | 16'h0001; // Never zero so it is the true MOVNZ/MOVEZ condition
		b = {8'($urandom) | 8'h01, 4'h0, 4'($urandom)}; // Upper byte set so SHIFT goes left
		put_set(1, a);
		put_set(2, b);
		put_set(3, 16'h0100);
		for (int k = int'(op_and); k <= int'(op_eq); k++) begin
			put_word(encode(opcode_e'(k), 1, 5, 2));
			put_store(3, 5, 15'h0100, alu_expect(opcode_e'(k), a, b));
		end

		// Right shift, an oversized shift and a true EQ through r6
		e = {8'h00, 4'h0, 4'($urandom)};
		put_set(6, e);
		put_word(encode(op_shift, 1, 5, 6));
		put_store(3, 5, 15'h0100, alu_expect(op_shift, a, e));
		e = {8'($urandom), 8'($urandom_range(255, word_w))};
		put_set(6, e);
		put_word(encode(op_shift, 1, 5, 6));
		put_store(3, 5, 15'h0100, alu_expect(op_shift, a, e));
		put_set(6, a);
		put_word(encode(op_eq, 1, 5, 6));
		put_store(3, 5, 15'h0100, alu_expect(op_eq, a, a));

		// Conditional moves against the always zero r0
		c = 16'($urandom);
		put_word(encode(op_mov, 2, 7, 0));
		put_store(3, 7, 15'h0100, b);
		put_set(8, c);
		put_word(encode(op_movnz, 2, 8, 0));
		put_store(3, 8, 15'h0100, c);
		put_word(encode(op_movnz, 2, 8, 1));
		put_store(3, 8, 15'h0100, b);
		put_word(encode(op_movez, 1, 8, 1));
		put_store(3, 8, 15'h0100, b);
		put_word(encode(op_movez, 1, 8, 0));
		put_store(3, 8, 15'h0100, a);

		d = 16'($urandom);
		put_set(9, d);
		put_set(10, 16'h0200);
		put_set(11, 16'h0300);
		put_store(10, 9, 15'h0200, d);
		put_word(encode(op_memr, 10, 12, 0));
		put_store(11, 12, 15'h0300, d); // Copy of the loaded word

		// Count r13 down to zero and branch back through r15
		count = 3 + $urandom_range(3, 0);
		put_set(13, 16'(count));
		put_set(14, '1);
		loop_top = prog_len + 2;
		put_set(4, 16'(loop_top));
		put_word(encode(op_memw, 3, 0, 13));
		put_word(encode(op_add, 13, 13, 14));
		put_word(encode(op_movnz, 4, 15, 13));
		put_word(encode(op_halt, 0, 0, 0));
		for (int n = count; n > 0; n--) begin
			exp_addr.push_back(15'h0100);
			exp_data.push_back(16'(n));
		end
		timeout_cycles = 40 * prog_len * num_programs + max_read_delay + reset_cycles;

		repeat (reset_cycles - 1) begin
			@(posedge clk);
			@(negedge clk);
			check_idle("while reset is held");
		end
		@(posedge clk);
		#1 mem_read_ready_stor_reset = 1'b0;
		repeat (2) begin
			@(negedge clk);
			check_idle("around reset release");
		end

		while (!halted)
			@(negedge clk);
		repeat (10) @(negedge clk); // Halt must hold with no memory traffic

		checks++;
		assert (u_data_mem_model.log_count == exp_data.size())
			else report_error($sformatf("%0d writes logged, expected %0d",
				u_data_mem_model.log_count, exp_data.size()));
		for (int i = 0; i < exp_data.size() && i < u_data_mem_model.log_count; i++) begin
			check_value($sformatf("write %0d address", i),
				16'(u_data_mem_model.log_addr[i]), 16'(exp_addr[i]));
			check_value($sformatf("write %0d data", i),
				u_data_mem_model.log_data[i], exp_data[i]);
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	initial begin
		wait (timeout_cycles != 0);
		repeat (timeout_cycles) @(posedge clk);
		$display("timeout: the core did not halt within %0d cycles", timeout_cycles);
		$display("checks: %0d, errors: %0d", checks, errors);
		$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

/* verif/data_mem_model.sv */
// Data memory model for the core testbench; answers reads after a random delay and logs every write
`timescale 1ns/1ps
`default_nettype none

module data_mem_model import cpu_pkg::*; #(
	parameter int max_delay = 6,
	parameter int log_depth = 64
) (
	input  logic     clk,
	input  logic     mem_read_ready_stor_reset,
	input  mem_req_t mem_req,
	output mem_rsp_t mem_rsp
);

	logic [word_w-1:0]     mem [2**mem_addr_w];
	logic [mem_addr_w-1:0] log_addr [log_depth];
	logic [word_w-1:0]     log_data [log_depth];
	int unsigned           log_count;
	logic                  busy;      // Read accepted, ready still pending
	int unsigned           wait_left;
	logic [mem_addr_w-1:0] read_addr;

	initial begin
		for (int i = 0; i < 2**mem_addr_w; i++)
			mem[i] = 16'(i * 40503) ^ 16'h5a3c; // Odd multiplier keeps every address distinct
		mem_rsp   = '0;
		busy      = 1'b0;
		log_count = 0;
		wait_left = 0;
		forever begin
			// Requests are sampled mid-cycle
			@(negedge clk);
			if (mem_read_ready_stor_reset) begin
				busy = 1'b0;
			end else begin
				if (mem_req.write) begin
					mem[mem_req.addr] = mem_req.wdata;
					if (log_count < log_depth) begin
						log_addr[log_count] = mem_req.addr;
						log_data[log_count] = mem_req.wdata;
					end
					log_count++;
				end
				if (mem_req.read && !busy && !mem_rsp.ready) begin
					busy      = 1'b1;
					read_addr = mem_req.addr;
					wait_left = $urandom_range(max_delay, 1);
				end
			end
			@(posedge clk);
			#1;
			mem_rsp.ready = 1'b0; // Ready is a single-cycle pulse
			if (busy) begin
				wait_left--;
				if (wait_left == 0) begin
					busy          = 1'b0;
					mem_rsp.ready = 1'b1;
					mem_rsp.rdata = mem[read_addr];
				end
			end
		end
	end

endmodule

`default_nettype wire
